// ==== tb.f ====
verilog/regfile_pkg.sv
verilog/regfile_ram.sv
verilog/regfile_lvt.sv
verilog/regfile_read_port.sv
verilog/regfile.sv
verification/regfile_checker.sv
verification/tb_regfile.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_regfile

status=0
out=$(./obj_dir/Vtb_regfile 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -q "TESTS PASSED"; then
   echo "run.sh: simulation passed"
   exit 0
else
   echo "run.sh: simulation failed"
   exit 1
fi

// ==== verification/tb_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_regfile import regfile_pkg::*; ();

   // ==========================================================================
   // Test constants
   // ==========================================================================

   localparam int AW           = $clog2(PREGS_DEF);
   localparam int WP           = WR_PORTS_DEF;
   localparam int RP           = RD_PORTS_DEF;
   localparam int VW           = VALUE_W_DEF;
   localparam int CLK_PERIOD   = 10;               // ns
   localparam int RESET_CYCLES = 3;
   localparam int RAND_CYCLES  = 400;
   localparam int MARGIN_NS    = 500;
   // Sum of all test lengths below, in clock cycles
   localparam int TOTAL_CYCLES = RESET_CYCLES + PREGS_DEF + WP * 16 + 8 + 16 + 8
                                 + RAND_CYCLES + 2;

   logic                     clka = 1'b0;
   logic                     reset;
   logic [WP-1:0]            wr_en;
   logic [WP-1:0][AW-1:0]    wr_addr;
   logic [WP-1:0][VW-1:0]    wr_data;
   logic [RP-1:0][AW-1:0]    rd_addr;
   wire  [RP-1:0][VW-1:0]    rd_data;
   int                       err_cnt;
   int                       chk_cnt;
   int                       err_mark = 0;       // Counts at the end of the previous test
   int                       chk_mark = 0;
   integer                   seed;
   logic [31:0]              rnd;
   logic [AW-1:0]            a;

   regfile dut_i (
      .clka (clka), .reset (reset), .wr_en (wr_en), .wr_addr (wr_addr),
      .wr_data (wr_data), .rd_addr (rd_addr), .rd_data (rd_data)
   );

   regfile_checker chk_i (
      .clka (clka), .reset (reset), .wr_en (wr_en), .wr_addr (wr_addr),
      .wr_data (wr_data), .rd_addr (rd_addr), .rd_data (rd_data),
      .err_cnt (err_cnt), .chk_cnt (chk_cnt)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clka = ~clka;
   end

   // Watchdog sized from the test lengths
   initial begin
      #(TOTAL_CYCLES * CLK_PERIOD + MARGIN_NS);
      $display("Run timed out: the tests did not finish within %0d ns",
               TOTAL_CYCLES * CLK_PERIOD + MARGIN_NS);
      $display("TESTS FAILED");
      $finish;
   end

   // ==========================================================================
   // Helpers
   // ==========================================================================

   function automatic logic [VW-1:0] random_word();
      return {$random(seed), $random(seed)};
   endfunction

   task automatic wait_cycle();
      @(negedge clka);                // Inputs change on the falling edge only
   endtask

   task automatic drive_idle();
      wr_en   = '0;
      wr_addr = '0;
      wr_data = '0;
   endtask

   task automatic read_all(input logic [AW-1:0] addr);
      for (int r = 0; r < RP; r++) begin
         rd_addr[r] = addr;
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s: %0d reads checked, %0d errors", num, name,
               chk_cnt - chk_mark, err_cnt - err_mark);
      chk_mark = chk_cnt;
      err_mark = err_cnt;
   endtask

   // ==========================================================================
   // Stimulus
   // ==========================================================================

   initial begin
      seed    = 61;
      reset   = 1'b1;
      rd_addr = '0;
      drive_idle();
      repeat (RESET_CYCLES) wait_cycle();
      reset = 1'b0;

      // Every register on every read port, rotated per port
      for (int i = 0; i < PREGS_DEF; i++) begin
         for (int r = 0; r < RP; r++) begin
            rd_addr[r] = AW'((i + r) % PREGS_DEF);
         end
         wait_cycle();
      end
      report_test(1, "zero after reset");

      // One write port at a time, then read back on all ports
      for (int w = 0; w < WP; w++) begin
         for (int k = 0; k < 8; k++) begin
            drive_idle();
            wr_en[w]   = 1'b1;
            wr_addr[w] = AW'(1 + w * 8 + k);
            wr_data[w] = random_word();
            read_all(AW'(w * 8 + k));          // Previous register of the run
            wait_cycle();
         end
         drive_idle();
         for (int k = 0; k < 8; k++) begin
            read_all(AW'(1 + w * 8 + k));
            wait_cycle();
         end
      end
      report_test(2, "single port write and read back");

      // Read the register being written in the same cycle
      for (int k = 0; k < 8; k++) begin
         drive_idle();
         wr_en[k % WP]   = 1'b1;
         wr_addr[k % WP] = AW'(20 + k);
         wr_data[k % WP] = random_word();
         read_all(AW'(20 + k));
         wait_cycle();
      end
      report_test(3, "same cycle forwarding");

      // All ports hit one register, then port 0 alone takes it back
      for (int k = 0; k < 4; k++) begin
         a = AW'(40 + k);
         read_all(a);
         for (int w = 0; w < WP; w++) begin
            wr_en[w]   = 1'b1;
            wr_addr[w] = a;
            wr_data[w] = random_word();
         end
         wait_cycle();
         drive_idle();                        // Stored value of the highest port
         wait_cycle();
         wr_en[0]   = 1'b1;
         wr_addr[0] = a;
         wr_data[0] = random_word();
         wait_cycle();
         drive_idle();
         wait_cycle();
      end
      report_test(4, "write collision priority");

      // r0 stays zero whatever is written to it
      for (int k = 0; k < 4; k++) begin
         read_all('0);
         for (int w = 0; w < WP; w++) begin
            wr_en[w]   = 1'b1;
            wr_addr[w] = '0;
            wr_data[w] = random_word() | 64'h1;
         end
         wait_cycle();
         drive_idle();
         wait_cycle();
      end
      report_test(5, "register zero");

      // Random mix, addresses often folded into r0..r7 to force hits
      for (int c = 0; c < RAND_CYCLES; c++) begin
         for (int w = 0; w < WP; w++) begin
            rnd        = $random(seed);
            wr_en[w]   = rnd[0];
            wr_addr[w] = rnd[1] ? (rnd[AW+1:2] & AW'(7)) : rnd[AW+1:2];
            wr_data[w] = random_word();
         end
         for (int r = 0; r < RP; r++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
               rd_addr[r] = wr_addr[int'(rnd[4:1]) % WP];   // Chase a live write
            end else begin
               rd_addr[r] = rnd[8] ? (rnd[AW+9:10] & AW'(7)) : rnd[AW+9:10];
            end
         end
         wait_cycle();
      end
      drive_idle();
      wait_cycle();
      report_test(6, "random traffic");

      $display("total: %0d reads checked, %0d errors", chk_cnt, err_cnt);
      if (chk_cnt == 0) begin
         $display("No read values were compared during the run");
      end
      if (err_cnt == 0 && chk_cnt > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/regfile_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Watches every DUT port and checks each read port against a shadow register file
module regfile_checker import regfile_pkg::*; #(
   parameter int PREGS    = PREGS_DEF,
   parameter int VALUE_W  = VALUE_W_DEF,
   parameter int WR_PORTS = WR_PORTS_DEF,
   parameter int RD_PORTS = RD_PORTS_DEF,
   localparam int AW      = $clog2(PREGS)
) (
   input  wire                               clka,
   input  wire                               reset,
   input  wire  [WR_PORTS-1:0]               wr_en,
   input  wire  [WR_PORTS-1:0][AW-1:0]       wr_addr,
   input  wire  [WR_PORTS-1:0][VALUE_W-1:0]  wr_data,
   input  wire  [RD_PORTS-1:0][AW-1:0]       rd_addr,
   input  wire  [RD_PORTS-1:0][VALUE_W-1:0]  rd_data,
   output int                                err_cnt,   // Mismatches so far
   output int                                chk_cnt    // Read values compared so far
);

   // ==========================================================================
   // Shadow register file
   // ==========================================================================

   logic [VALUE_W-1:0] shadow [0:PREGS-1];   // Committed value of every register
   int                 errs   = 0;
   int                 checks = 0;

   assign err_cnt = errs;
   assign chk_cnt = checks;

   // Every register starts at zero, as the DUT RAMs do
   initial begin
      for (int n = 0; n < PREGS; n++) begin
         shadow[n] = '0;
      end
   end

   // Expected read value for one address
   // Newest committed value, overridden by a write to the same register
   // this cycle (highest port wins), and r0 always zero
   function automatic logic [VALUE_W-1:0] expect_read(
      input logic [AW-1:0]                      addr,
      input logic [WR_PORTS-1:0]                en,
      input logic [WR_PORTS-1:0][AW-1:0]        wa,
      input logic [WR_PORTS-1:0][VALUE_W-1:0]   wd
   );
      logic [VALUE_W-1:0] val;
      val = shadow[addr];
      for (int w = 0; w < WR_PORTS; w++) begin
         if (en[w] && (wa[w] == addr)) begin
            val = wd[w];              // Later port replaces an earlier one
         end
      end
      if (addr == '0) begin
         val = '0;
      end
      return val;
   endfunction

   // ==========================================================================
   // Compare and commit
   // ==========================================================================

   // Runs at the rising edge, where the DUT still shows the settled values
   // of the cycle that is ending; the RAMs only change in the NBA region
   always @(posedge clka) begin : compare
      logic [VALUE_W-1:0] exp_val;
      if (!reset) begin
         for (int r = 0; r < RD_PORTS; r++) begin
            exp_val = expect_read(rd_addr[r], wr_en, wr_addr, wr_data);
            checks++;
            if (rd_data[r] !== exp_val) begin
               errs++;
               $display("ERR rd_data[%0d] addr %h expected %h actual %h at %0t ns",
                        r, rd_addr[r], exp_val, rd_data[r], $time);
            end
         end
         // Commit this cycle's writes, low port first so the highest lands last
         for (int w = 0; w < WR_PORTS; w++) begin
            if (wr_en[w]) begin
               shadow[wr_addr[w]] = wr_data[w];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

// Multi-ported physical register file
// WR_PORTS x RD_PORTS simple dual-port RAMs steered by a live value table
module regfile import regfile_pkg::*; #(
   parameter int PREGS    = PREGS_DEF,     // Power of two
   parameter int VALUE_W  = VALUE_W_DEF,
   parameter int WR_PORTS = WR_PORTS_DEF,
   parameter int RD_PORTS = RD_PORTS_DEF,
   localparam int AW      = $clog2(PREGS),
   localparam int SW      = bank_sel_w(WR_PORTS)
) (
   input  wire                               clka,
   input  wire                               reset,
   input  wire  [WR_PORTS-1:0]               wr_en,
   input  wire  [WR_PORTS-1:0][AW-1:0]       wr_addr,
   input  wire  [WR_PORTS-1:0][VALUE_W-1:0]  wr_data,
   input  wire  [RD_PORTS-1:0][AW-1:0]       rd_addr,
   output wire  [RD_PORTS-1:0][VALUE_W-1:0]  rd_data
);

   // ==========================================================================
   // Internal nets
   // ==========================================================================

   wire [RD_PORTS-1:0][WR_PORTS-1:0][VALUE_W-1:0] ram_dout;  // [read port][bank]
   wire [RD_PORTS-1:0][SW-1:0]                    bank_sel;  // LVT lookups

   genvar w, r;

   // ==========================================================================
   // RAM array
   // ==========================================================================

   // Bank w is written only by write port w
   // Inside a bank, one RAM per read port gives each reader its own read port
   generate
      for (w = 0; w < WR_PORTS; w++) begin : g_bank
         for (r = 0; r < RD_PORTS; r++) begin : g_copy
            regfile_ram #(
               .DEP (PREGS),
               .WID (VALUE_W)
            ) ram_i (
               .clka    (clka),
               .wr_en   (wr_en[w]),
               .wr_addr (wr_addr[w]),
               .wr_data (wr_data[w]),
               .rd_addr (rd_addr[r]),
               .rd_data (ram_dout[r][w])   // Candidate w for read port r
            );
         end
      end
   endgenerate

   // ==========================================================================
   // Live value table
   // ==========================================================================

   regfile_lvt #(
      .PREGS    (PREGS),
      .WR_PORTS (WR_PORTS),
      .RD_PORTS (RD_PORTS)
   ) lvt_i (
      .clka     (clka),
      .reset    (reset),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .rd_addr  (rd_addr),
      .bank_sel (bank_sel)
   );

   // ==========================================================================
   // Read ports
   // ==========================================================================

   generate
      for (r = 0; r < RD_PORTS; r++) begin : g_rd
         regfile_read_port #(
            .PREGS    (PREGS),
            .VALUE_W  (VALUE_W),
            .WR_PORTS (WR_PORTS)
         ) rd_i (
            .rd_addr   (rd_addr[r]),
            .bank_sel  (bank_sel[r]),
            .bank_data (ram_dout[r]),
            .wr_en     (wr_en),          // All writers, for forwarding
            .wr_addr   (wr_addr),
            .wr_data   (wr_data),
            .rd_data   (rd_data[r])
         );
      end
   endgenerate

endmodule

`default_nettype wire

// ==== verilog/regfile_read_port.sv ====
`timescale 1ns/1ps
`default_nettype none

// One read port of the register file
// Picks the bank named by the LVT, then applies same-cycle forwarding and r0
module regfile_read_port import regfile_pkg::*; #(
   parameter int PREGS    = PREGS_DEF,
   parameter int VALUE_W  = VALUE_W_DEF,
   parameter int WR_PORTS = WR_PORTS_DEF,
   localparam int AW      = $clog2(PREGS),
   localparam int SW      = bank_sel_w(WR_PORTS)
) (
   input  wire                [AW-1:0] rd_addr,    // Register being read
   input  wire                [SW-1:0] bank_sel,   // From the LVT
   input  wire  [WR_PORTS-1:0][VALUE_W-1:0] bank_data, // This port's RAM copy per bank
   input  wire  [WR_PORTS-1:0]          wr_en,      // Current write strobes
   input  wire  [WR_PORTS-1:0][AW-1:0]  wr_addr,
   input  wire  [WR_PORTS-1:0][VALUE_W-1:0] wr_data,
   output logic          [VALUE_W-1:0] rd_data
);

   // ==========================================================================
   // Stored value
   // ==========================================================================

   logic [VALUE_W-1:0] stored_data;   // Newest value already written
   logic [VALUE_W-1:0] fwd_data;      // Value being written this cycle
   logic               fwd_hit;       // Some write port targets rd_addr now

   // Only the bank named by the LVT holds current data
   // The other banks keep stale copies of older writes
   assign stored_data = bank_data[bank_sel];

   // ==========================================================================
   // Forwarding
   // ==========================================================================

   // Scan low to high so the highest matching port ends up selected,
   // matching the LVT priority for writes in the same cycle
   always_comb begin
      fwd_hit  = 1'b0;
      fwd_data = '0;
      for (int w = 0; w < WR_PORTS; w++) begin
         if (wr_en[w] && (wr_addr[w] == rd_addr)) begin
            fwd_hit  = 1'b1;
            fwd_data = wr_data[w];   // Later ports overwrite earlier ones
         end
      end
   end

   // ==========================================================================
   // Output select
   // ==========================================================================

   always_comb begin
      if (rd_addr == '0) begin
         rd_data = '0;                // r0 is hardwired to zero
      end else if (fwd_hit) begin
         rd_data = fwd_data;          // Bypass the RAM write latency
      end else begin
         rd_data = stored_data;
      end
   end

   // ==========================================================================
   // Checks
   // ==========================================================================

   // r0 must read zero no matter what the LVT, banks or forward path hold
   // Deferred so that settling of the input paths does not trip it
   always_comb begin
      r0_zero_a : assert final ((rd_addr != '0) || (rd_data == '0))
         else $error("regfile_read_port r0 read returned %h", rd_data);
   end

endmodule

`default_nettype wire

// ==== verilog/regfile_lvt.sv ====
`timescale 1ns/1ps
`default_nettype none

// Live value table
// For each physical register it remembers which write port's bank holds the newest value
module regfile_lvt import regfile_pkg::*; #(
   parameter int PREGS    = PREGS_DEF,
   parameter int WR_PORTS = WR_PORTS_DEF,
   parameter int RD_PORTS = RD_PORTS_DEF,
   localparam int AW      = $clog2(PREGS),        // Register address bits
   localparam int SW      = bank_sel_w(WR_PORTS)  // Bank select bits
) (
   input  wire                          clka,
   input  wire                          reset,     // Synchronous active high
   input  wire    [WR_PORTS-1:0]        wr_en,     // One strobe per write port
   input  wire    [WR_PORTS-1:0][AW-1:0] wr_addr,
   input  wire    [RD_PORTS-1:0][AW-1:0] rd_addr,  // Lookup address per read port
   output logic   [RD_PORTS-1:0][SW-1:0] bank_sel  // Bank holding newest data
);

   // ==========================================================================
   // Table storage
   // ==========================================================================

   // One write-port index per physical register
   logic [SW-1:0] lvt [0:PREGS-1];

   // Update
   // Ports are scanned low to high, so the last assignment that lands belongs
   // to the highest enabled port hitting a given register
   always_ff @(posedge clka) begin
      if (reset) begin
         for (int p = 0; p < PREGS; p++) begin
            lvt[p] <= '0;                 // All registers live in bank 0
         end
      end else begin
         for (int w = 0; w < WR_PORTS; w++) begin
            if (wr_en[w]) begin
               lvt[wr_addr[w]] <= SW'(w); // Record the writing port
            end
         end
      end
   end

   // ==========================================================================
   // Lookup
   // ==========================================================================

   // Combinational lookup with one table read per read port
   always_comb begin
      for (int r = 0; r < RD_PORTS; r++) begin
         bank_sel[r] = lvt[rd_addr[r]];
      end
   end

   // ==========================================================================
   // Checks
   // ==========================================================================

   // The table must only ever name a bank that exists and hold known entries
   // A bad or unknown index would make the read port pick a nonexistent RAM
   genvar r;
   generate
      for (r = 0; r < RD_PORTS; r++) begin : g_sel_chk
         bank_sel_range_a : assert property (
            @(posedge clka) disable iff (reset)
            !$isunknown(bank_sel[r]) && (int'(bank_sel[r]) < WR_PORTS)
         ) else $error("regfile_lvt bank_sel[%0d] unknown or out of range: %0d",
                       r, bank_sel[r]);
      end
   endgenerate

endmodule

`default_nettype wire

// ==== verilog/regfile_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// One write port, one read port
// Used as a single bank slice, so every read port sees a private copy
module regfile_ram #(
   parameter int DEP = 64,           // Words
   parameter int WID = 64,           // Bits per word
   localparam int AW = $clog2(DEP)   // Address bits
) (
   input  wire           clka,
   input  wire           wr_en,      // Write strobe, sampled on the rising edge
   input  wire  [AW-1:0] wr_addr,
   input  wire [WID-1:0] wr_data,
   input  wire  [AW-1:0] rd_addr,    // Combinational read address
   output wire [WID-1:0] rd_data
);

   // ==========================================================================
   // Storage
   // ==========================================================================

   (* ram_style = "distributed" *)
   logic [WID-1:0] mem [0:DEP-1];

   // Power-up contents are zero, so every register reads zero before any write
   initial begin
      for (int n = 0; n < DEP; n++) begin
         mem[n] = '0;
      end
   end

   // Write on the clock edge
   always_ff @(posedge clka) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;     // Old data visible until the edge
      end
   end

   // Asynchronous read, LUT RAM style
   assign rd_data = mem[rd_addr];

   // ==========================================================================
   // Checks
   // ==========================================================================

   // A strobed write must target a known location
   // An unknown address would corrupt an unpredictable word in the bank
   wr_addr_known_a : assert property (@(posedge clka) wr_en |-> !$isunknown(wr_addr))
      else $error("regfile_ram write address unknown while wr_en high");

endmodule

`default_nettype wire

// ==== verilog/regfile_pkg.sv ====
`default_nettype none

package regfile_pkg;

   // ==========================================================================
   // Default register-file dimensions
   // ==========================================================================

   localparam int PREGS_DEF    = 64;   // Physical registers, power of two
   localparam int VALUE_W_DEF  = 64;   // Bits per register
   localparam int WR_PORTS_DEF = 2;    // Write ports, one RAM bank each
   localparam int RD_PORTS_DEF = 4;    // Read ports, one RAM per bank each

   // ==========================================================================
   // Bank select width
   // ==========================================================================

   // Width of an index that names one of the write ports
   // A single write port still needs one select bit so the LVT has a field
   function automatic int bank_sel_w(input int ports);
      int w;
      w = $clog2(ports);
      if (w < 1) begin
         w = 1;                       // Never a zero-width vector
      end
      return w;
   endfunction

endpackage

`default_nettype wire
